//--- rtl/muldiv_isa_pkg.sv
`default_nettype none

package muldiv_isa_pkg;

  // funct3 field of the M extension, opcode OP with funct7 = 0000001
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } funct3_e;

  function automatic logic is_div_op(funct3_e f);
    return f inside {DIV, DIVU, REM, REMU};
  endfunction

  function automatic logic is_signed_div(funct3_e f);
    return f inside {DIV, REM};  // operands go through magnitude
  endfunction

  // upper half of the product, or the remainder
  function automatic logic selects_hi(funct3_e f);
    return f inside {MULH, MULHSU, MULHU, REM, REMU};
  endfunction

  function automatic logic mul_a_signed(funct3_e f);
    return f inside {MULH, MULHSU};
  endfunction

  function automatic logic mul_b_signed(funct3_e f);
    return f == MULH;
  endfunction

endpackage

`default_nettype wire

//--- rtl/muldiv_dp_pkg.sv
`default_nettype none

package muldiv_dp_pkg;

  localparam int XLEN = 32;

  // decoded operation as launched into the execute units
  typedef struct packed {
    logic            go;      // one cycle per accepted start
    logic            is_div;
    logic            sel_hi;
    logic            negate;  // result needs sign correction
    logic            a_sx;
    logic            b_sx;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
  } muldiv_op_t;

  typedef struct packed {
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
  } mul_word_t;

  typedef struct packed {
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] quo;
  } div_word_t;

  // one 64-bit word, product halves or remainder and quotient
  typedef union packed {
    mul_word_t mul;
    div_word_t div;
  } exec_word_u;

  typedef struct packed {
    logic       valid;
    logic       sel_hi;
    logic       negate;
    exec_word_u data;
  } exec_res_t;

endpackage

`default_nettype wire

//--- rtl/muldiv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_decode (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  muldiv_isa_pkg::funct3_e        funct3,
  input  logic [muldiv_dp_pkg::XLEN-1:0] a,
  input  logic [muldiv_dp_pkg::XLEN-1:0] b,
  input  logic                           done,
  output logic                           busy,
  output muldiv_dp_pkg::muldiv_op_t      op
);
  import muldiv_isa_pkg::*;
  import muldiv_dp_pkg::*;

  logic            accept;
  logic            a_neg;
  logic            b_neg;
  logic            sdiv;
  logic            negate_d;
  logic [XLEN-1:0] mag_a;
  logic [XLEN-1:0] mag_b;

  logic            go_q;
  logic            is_div_q;
  logic            sel_hi_q;
  logic            negate_q;
  logic            a_sx_q;
  logic            b_sx_q;
  logic [XLEN-1:0] op_a_q;
  logic [XLEN-1:0] op_b_q;

  assign accept = start & ~busy;  // start while busy is dropped
  assign a_neg  = a[XLEN-1];
  assign b_neg  = b[XLEN-1];
  assign sdiv   = is_signed_div(funct3);
  assign mag_a  = (sdiv && a_neg) ? -a : a;
  assign mag_b  = (sdiv && b_neg) ? -b : b;

  // quotient sign flips only for a nonzero divisor, remainder follows dividend
  assign negate_d = ((funct3 == DIV) && (a_neg != b_neg) && (|b)) ||
                    ((funct3 == REM) && a_neg);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy <= 1'b0;
      go_q <= 1'b0;
    end else begin
      go_q <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;  // drops the edge after done
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      is_div_q <= is_div_op(funct3);
      sel_hi_q <= selects_hi(funct3);
      negate_q <= negate_d;
      a_sx_q   <= mul_a_signed(funct3);
      b_sx_q   <= mul_b_signed(funct3);
      op_a_q   <= mag_a;
      op_b_q   <= mag_b;
    end
  end

  always_comb begin
    op.go     = go_q;
    op.is_div = is_div_q;
    op.sel_hi = sel_hi_q;
    op.negate = negate_q;
    op.a_sx   = a_sx_q;
    op.b_sx   = b_sx_q;
    op.op_a   = op_a_q;
    op.op_b   = op_b_q;
  end

endmodule

`default_nettype wire

//--- rtl/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  muldiv_dp_pkg::muldiv_op_t op,
  output muldiv_dp_pkg::exec_res_t  res_o
);
  import muldiv_dp_pkg::*;

  logic                   fire;
  logic signed [XLEN:0]   a_ext;
  logic signed [XLEN:0]   b_ext;
  logic signed [2*XLEN+1:0] prod;

  logic                   valid_q;
  logic                   sel_hi_q;
  logic [2*XLEN-1:0]      prod_q;

  assign fire = op.go & ~op.is_div;

  // 33 bits each so one signed multiplier covers all four flavours
  assign a_ext = {op.a_sx & op.op_a[XLEN-1], op.op_a};
  assign b_ext = {op.b_sx & op.op_b[XLEN-1], op.op_b};
  assign prod  = a_ext * b_ext;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fire;  // single cycle
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      prod_q   <= prod[2*XLEN-1:0];  // top two bits are sign copies
      sel_hi_q <= op.sel_hi;
    end
  end

  always_comb begin
    res_o.valid       = valid_q;
    res_o.sel_hi      = sel_hi_q;
    res_o.negate      = 1'b0;
    res_o.data.mul.hi = prod_q[2*XLEN-1:XLEN];
    res_o.data.mul.lo = prod_q[XLEN-1:0];
  end

endmodule

`default_nettype wire

//--- rtl/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  muldiv_dp_pkg::muldiv_op_t op,
  output muldiv_dp_pkg::exec_res_t  res_o
);
  import muldiv_dp_pkg::*;

  localparam int IDX_W = $clog2(XLEN);

  logic             load;
  logic             fits;
  logic [XLEN:0]    rem_shift;

  logic             active;
  logic             valid_q;
  logic [IDX_W-1:0] index;

  logic [XLEN-1:0]  numerator;
  logic [XLEN-1:0]  divisor;
  logic [XLEN-1:0]  quotient;
  logic [XLEN-1:0]  remainder;
  logic             negate_q;
  logic             sel_hi_q;

  assign load = op.go & op.is_div;

  // bring down the next dividend bit, one extra bit for divisors above 2^31
  assign rem_shift = {remainder, numerator[index]};
  assign fits      = rem_shift >= {1'b0, divisor};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active  <= 1'b0;
      valid_q <= 1'b0;
      index   <= '0;
    end else begin
      valid_q <= 1'b0;
      if (load) begin
        active <= 1'b1;
        index  <= IDX_W'(XLEN - 1);  // msb first
      end else if (active) begin
        index <= index - 1'b1;
        if (index == '0) begin
          active  <= 1'b0;
          valid_q <= 1'b1;  // last bit lands with valid
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      numerator <= op.op_a;
      divisor   <= op.op_b;
      quotient  <= '0;
      remainder <= '0;
      negate_q  <= op.negate;
      sel_hi_q  <= op.sel_hi;
    end else if (active) begin
      if (fits) begin
        // result is below the divisor so the low bits are enough
        remainder       <= rem_shift[XLEN-1:0] - divisor;
        quotient[index] <= 1'b1;
      end else begin
        remainder <= rem_shift[XLEN-1:0];
      end
    end
  end

  // zero divisor always fits, giving all ones and rem = dividend
  always_comb begin
    res_o.valid        = valid_q;
    res_o.sel_hi       = sel_hi_q;
    res_o.negate       = negate_q;
    res_o.data.div.rem = remainder;
    res_o.data.div.quo = quotient;
  end

endmodule

`default_nettype wire

//--- rtl/muldiv_result.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_result (
  input  logic                           clk,
  input  logic                           rst,
  input  muldiv_dp_pkg::exec_res_t       mul_res,
  input  muldiv_dp_pkg::exec_res_t       div_res,
  output logic [muldiv_dp_pkg::XLEN-1:0] res,
  output logic                           done
);
  import muldiv_dp_pkg::*;

  logic            any_valid;
  logic            neg;
  logic [XLEN-1:0] half;
  logic [XLEN-1:0] fixed;

  assign any_valid = mul_res.valid | div_res.valid;

  // only one unit is ever valid, one operation in flight
  always_comb begin
    if (mul_res.valid) begin
      half = mul_res.sel_hi ? mul_res.data.mul.hi : mul_res.data.mul.lo;
      neg  = mul_res.negate;
    end else begin
      half = div_res.sel_hi ? div_res.data.div.rem : div_res.data.div.quo;
      neg  = div_res.negate;
    end
  end

  assign fixed = neg ? -half : half;  // sign fix for DIV and REM

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done <= 1'b0;
      res  <= '0;
    end else begin
      done <= any_valid;
      if (any_valid) begin
        res <= fixed;  // held until next done
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/muldiv_top.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  muldiv_isa_pkg::funct3_e        funct3,
  input  logic [muldiv_dp_pkg::XLEN-1:0] a,
  input  logic [muldiv_dp_pkg::XLEN-1:0] b,
  output logic [muldiv_dp_pkg::XLEN-1:0] res,
  output logic                           done,
  output logic                           busy
);
  import muldiv_dp_pkg::*;

  muldiv_op_t op;       // shared by both execute units
  exec_res_t  mul_res;
  exec_res_t  div_res;

  muldiv_decode decode_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .funct3 (funct3),
    .a      (a),
    .b      (b),
    .done   (done),
    .busy   (busy),
    .op     (op)
  );

  mul_unit mul_i (
    .clk   (clk),
    .rst   (rst),
    .op    (op),
    .res_o (mul_res)
  );

  div_unit div_i (
    .clk   (clk),
    .rst   (rst),
    .op    (op),
    .res_o (div_res)
  );

  muldiv_result result_i (
    .clk     (clk),
    .rst     (rst),
    .mul_res (mul_res),
    .div_res (div_res),
    .res     (res),
    .done    (done)
  );

endmodule

`default_nettype wire

//--- verif/muldiv_chk.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_chk (
  input logic clk,
  input logic rst,
  input logic start,
  input logic busy,
  input logic done
);

  int fail_count = 0;  // tally for the end-of-run summary

  done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      fail_count++;
    end

  done_while_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
    else begin
      $error("done pulsed while busy was low");
      fail_count++;
    end

  // accepted start raises busy on the next edge
  start_sets_busy: assert property (@(posedge clk) disable iff (rst) (start && !busy) |=> busy)
    else begin
      $error("accepted start did not raise busy");
      fail_count++;
    end

endmodule

bind muldiv_top muldiv_chk chk_i (
  .clk   (clk),
  .rst   (rst),
  .start (start),
  .busy  (busy),
  .done  (done)
);

`default_nettype wire

//--- verif/muldiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;
  import muldiv_isa_pkg::*;

  localparam int N_OPS       = 180;  // upper bound on operations issued
  localparam int MAX_WAIT    = 60;   // cycles allowed for one done
  localparam int WATCHDOG_NS = N_OPS * 40 * 4 + 2000;

  logic        clk;
  logic        rst;
  logic        start;
  funct3_e     funct3;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic        done;
  logic        busy;

  logic [31:0] lfsr;
  logic [31:0] last_res;  // res must hold this until the next done
  int          checks;
  int          errors;
  int          test_base;

  muldiv_top dut_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .funct3 (funct3),
    .a      (a),
    .b      (b),
    .res    (res),
    .done   (done),
    .busy   (busy)
  );

  always #2 clk = ~clk;

  // taps 32 22 2 1 and one step per bit taken
  function automatic logic [31:0] lfsr_word();
    logic [31:0] w;
    logic        fb;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      w    = {w[30:0], fb};
    end
    return w;
  endfunction

  // RV32M results straight from the ISA rules
  function automatic logic [31:0] ref_result(funct3_e f, logic [31:0] x, logic [31:0] y);
    logic signed [63:0] sx;
    logic signed [63:0] sy;
    logic signed [63:0] uy;
    logic        [63:0] ux;
    logic        [63:0] p;
    sx = {{32{x[31]}}, x};
    sy = {{32{y[31]}}, y};
    ux = {32'b0, x};
    uy = {32'b0, y};
    case (f)
      MULH:    p = sx * sy;
      MULHSU:  p = sx * uy;
      default: p = ux * uy;
    endcase
    case (f)
      MUL:                 return p[31:0];
      MULH, MULHSU, MULHU: return p[63:32];
      DIVU:                return (y == 0) ? '1 : x / y;
      REMU:                return (y == 0) ? x : x % y;
      DIV: begin
        if (y == 0) return '1;
        if (x == 32'h8000_0000 && y == '1) return x;  // overflow
        return $signed(x) / $signed(y);
      end
      default: begin
        if (y == 0) return x;
        if (x == 32'h8000_0000 && y == '1) return '0;
        return $signed(x) % $signed(y);
      end
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%-20s %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // one operation from start until busy drops again
  task automatic run_op(input funct3_e f, input logic [31:0] x, input logic [31:0] y);
    logic [31:0] exp;
    int          lat;
    int          want;
    exp    = ref_result(f, x, y);
    want   = (f inside {DIV, DIVU, REM, REMU}) ? 34 : 2;
    funct3 = f;
    a      = x;
    b      = y;
    start  = 1'b1;
    @(posedge clk);  // accepting edge
    #0.5;
    start = 1'b0;
    lat   = 0;
    while (!done && lat < MAX_WAIT) begin
      check_value("res (held)", res, last_res);
      @(posedge clk);
      #0.5;
      lat++;
    end
    checks++;
    assert (done) else begin
      $display("no done pulse from the DUT within %0d cycles for %s", MAX_WAIT, f.name());
      errors++;
    end
    if (done) begin
      check_value($sformatf("done latency %s", f.name()), lat, want);
      check_value($sformatf("res %s", f.name()), res, exp);
    end
    last_res = res;
    @(posedge clk);  // busy drops here
    #0.5;
    check_value("busy", 32'(busy), 0);
  endtask

  task automatic check_reset_state();
    check_value("done", 32'(done), 0);
    check_value("busy", 32'(busy), 0);
    check_value("res", res, 0);
    report_test("reset state");
  endtask

  task automatic mul_family();
    logic [31:0] xs [6] = '{32'h7, 32'hffff_fff9, 32'h8000_0000,
                           32'h8000_0000, 32'h0, 32'hffff_ffff};
    logic [31:0] ys [6] = '{32'h3, 32'h3, 32'hffff_ffff,
                           32'h8000_0000, 32'h1234_5678, 32'hffff_ffff};
    logic [31:0] x;
    logic [31:0] y;
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 4; k++) run_op(funct3_e'(k), xs[i], ys[i]);
    end
    for (int i = 0; i < 20; i++) begin
      x = lfsr_word();
      y = lfsr_word();
      for (int k = 0; k < 4; k++) run_op(funct3_e'(k), x, y);
    end
    report_test("multiply family");
  endtask

  task automatic div_family();
    logic [31:0] xs [4] = '{32'd100, -32'd100, 32'd100, -32'd100};
    logic [31:0] ys [4] = '{32'd7, 32'd7, -32'd7, -32'd7};
    logic [31:0] x;
    logic [31:0] y;
    for (int i = 0; i < 4; i++) begin
      for (int k = 4; k < 8; k++) run_op(funct3_e'(k), xs[i], ys[i]);
    end
    for (int i = 0; i < 10; i++) begin
      x = lfsr_word();
      y = lfsr_word();
      if (i[0]) y = y >> 20;  // small divisors too
      for (int k = 4; k < 8; k++) run_op(funct3_e'(k), x, y);
    end
    report_test("divide family");
  endtask

  task automatic div_corners();
    for (int k = 4; k < 8; k++) begin
      run_op(funct3_e'(k), 32'd12345, 32'd0);
      run_op(funct3_e'(k), 32'h8000_0000, 32'd0);
    end
    run_op(DIV, 32'h8000_0000, 32'hffff_ffff);
    run_op(REM, 32'h8000_0000, 32'hffff_ffff);
    run_op(DIVU, 32'h8000_0000, 32'hffff_ffff);
    run_op(REMU, 32'h8000_0000, 32'hffff_ffff);
    report_test("divide corners");
  endtask

  task automatic start_while_busy();
    logic [31:0] exp;
    int          pulses;
    exp    = ref_result(DIVU, 32'd1000, 32'd7);
    funct3 = DIVU;
    a      = 32'd1000;
    b      = 32'd7;
    start  = 1'b1;
    @(posedge clk);
    #0.5;
    start = 1'b0;
    repeat (5) @(posedge clk);
    #0.5;
    funct3 = MUL;  // must be dropped
    a      = 32'd3;
    b      = 32'd5;
    start  = 1'b1;
    @(posedge clk);
    #0.5;
    start  = 1'b0;
    pulses = 0;
    for (int i = 0; i < 40; i++) begin
      @(posedge clk);
      #0.5;
      if (done) begin
        pulses++;
        check_value("res", res, exp);
      end
    end
    check_value("done pulses", pulses, 1);
    check_value("busy", 32'(busy), 0);
    last_res = res;
    report_test("start while busy");
  endtask

  task automatic back_to_back();
    run_op(MULHU, 32'hdead_beef, 32'h0000_1000);
    run_op(DIV, -32'd77, 32'd5);
    run_op(MUL, 32'h0001_0001, 32'h0001_0001);
    report_test("back to back");
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    start     = 1'b0;
    funct3    = MUL;
    a         = '0;
    b         = '0;
    lfsr      = 32'd37;
    last_res  = '0;
    checks    = 0;
    errors    = 0;
    test_base = 0;
    repeat (2) @(posedge clk);
    #0.5;
    rst = 1'b0;
    check_reset_state();
    mul_family();
    div_family();
    div_corners();
    start_while_busy();
    back_to_back();
    errors += dut_i.chk_i.fail_count;  // protocol assertions
    $display("checks %0d, errors %0d, protocol failures %0d",
             checks, errors, dut_i.chk_i.fail_count);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #WATCHDOG_NS;
    $display("watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/muldiv_isa_pkg.sv
rtl/muldiv_dp_pkg.sv
rtl/muldiv_decode.sv
rtl/mul_unit.sv
rtl/div_unit.sv
rtl/muldiv_result.sv
rtl/muldiv_top.sv
verif/muldiv_chk.sv
verif/muldiv_tb.sv

//--- Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := muldiv_tb
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log
PASS  := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
